/* source/dcache_pkg.sv */
package dcache_pkg;

  // Byte lanes on the 32-bit data path
  localparam int BYTE_LANES = 4;

  // Load width and sign codes from instr[14:12]
  localparam logic [2:0] FUNCT3_LB  = 3'b000;
  localparam logic [2:0] FUNCT3_LH  = 3'b001;
  localparam logic [2:0] FUNCT3_LW  = 3'b010;
  localparam logic [2:0] FUNCT3_LBU = 3'b100;
  localparam logic [2:0] FUNCT3_LHU = 3'b101;

  // Store width codes of which only the low two bits matter
  localparam logic [2:0] FUNCT3_SB  = 3'b000;
  localparam logic [2:0] FUNCT3_SH  = 3'b001;
  localparam logic [2:0] FUNCT3_SW  = 3'b010;

  typedef enum logic [1:0] {
    CACHE_IDLE,   // Serving hits, waiting for a miss or a store
    CACHE_WRITE,  // Single write-through transfer on the bus
    CACHE_FILL    // Burst read of one line into the victim way
  } cache_state_t;

endpackage

/* source/load_format.sv */
`timescale 1ns/1ps

module load_format (
  input  logic [31:0] ram_data_i,   // Raw word from the data array
  input  logic [1:0]  byte_off_i,   // Byte offset within the word
  input  logic [2:0]  funct3_i,     // Load width and sign
  output logic [31:0] load_data_o   // Register-ready value
);

  logic [31:0] shifted;

  // Move the addressed byte or halfword down to bit 0
  assign shifted = ram_data_i >> {byte_off_i, 3'b000};

  always_comb begin
    case (funct3_i)
      dcache_pkg::FUNCT3_LB: begin
        load_data_o = {{24{shifted[7]}}, shifted[7:0]};
      end
      dcache_pkg::FUNCT3_LH: begin
        load_data_o = {{16{shifted[15]}}, shifted[15:0]};
      end
      dcache_pkg::FUNCT3_LBU: begin
        load_data_o = {24'h00_0000, shifted[7:0]};
      end
      dcache_pkg::FUNCT3_LHU: begin
        load_data_o = {16'h0000, shifted[15:0]};
      end
      default: begin
        load_data_o = ram_data_i;  // LW and reserved codes
      end
    endcase
  end

endmodule

/* source/store_format.sv */
`timescale 1ns/1ps

module store_format (
  input  logic [31:0]                       store_data_i,  // Register value to store
  input  logic [1:0]                        byte_off_i,
  input  logic [1:0]                        width_i,       // funct3[1:0]
  output logic [31:0]                       lane_data_o,
  output logic [dcache_pkg::BYTE_LANES-1:0] lane_en_o
);

  localparam int LANES = dcache_pkg::BYTE_LANES;

  localparam logic [LANES-1:0] ONE_LANE  = {{(LANES - 1){1'b0}}, 1'b1};
  localparam logic [LANES-1:0] TWO_LANES = {{(LANES - 2){1'b0}}, 2'b11};

  always_comb begin
    case (width_i)
      dcache_pkg::FUNCT3_SB[1:0]: begin
        lane_data_o = {4{store_data_i[7:0]}};  // Same byte on every lane
        lane_en_o   = ONE_LANE << byte_off_i;
      end
      dcache_pkg::FUNCT3_SH[1:0]: begin
        lane_data_o = {2{store_data_i[15:0]}};
        // Halfwords sit on lanes 0-1 or 2-3
        lane_en_o   = TWO_LANES << {byte_off_i[1], 1'b0};
      end
      dcache_pkg::FUNCT3_SW[1:0]: begin
        lane_data_o = store_data_i;
        lane_en_o   = '1;
      end
      default: begin
        lane_data_o = store_data_i;
        lane_en_o   = '0;  // Reserved width writes nothing
      end
    endcase
  end

endmodule

/* source/dcache_tag_array.sv */
`timescale 1ns/1ps

module dcache_tag_array #(
  parameter int SETS  = 64,
  parameter int TAG_W = 6
) (
  input  logic                    cpu_clock_i,
  input  logic                    rst_n_i,
  input  logic [$clog2(SETS)-1:0] set_i,
  input  logic [TAG_W-1:0]        tag_i,
  input  logic                    lookup_i,      // Qualifies the compare
  output logic [1:0]              hit_o,         // One bit per way
  output logic                    hit_way_o,
  output logic                    victim_way_o,  // Way to fill on a miss
  input  logic                    update_i,      // Install tag_i into the victim way
  input  logic                    mru_touch_i    // Record the hit way as most recent
);

  logic [TAG_W-1:0] tag0_q [SETS];
  logic [TAG_W-1:0] tag1_q [SETS];
  logic [SETS-1:0]  valid0_q;
  logic [SETS-1:0]  valid1_q;
  logic [SETS-1:0]  mru_q;     // 1 means way 1 was used last
  logic             valid0;
  logic             valid1;

  assign valid0 = valid0_q[set_i];
  assign valid1 = valid1_q[set_i];

  // Both ways compared in parallel
  assign hit_o[0]  = lookup_i & valid0 & (tag0_q[set_i] == tag_i);
  assign hit_o[1]  = lookup_i & valid1 & (tag1_q[set_i] == tag_i);
  assign hit_way_o = hit_o[1];

  // An empty way first, otherwise the one not used last
  assign victim_way_o = !valid0 ? 1'b0 :
                        !valid1 ? 1'b1 : ~mru_q[set_i];

  always_ff @(posedge cpu_clock_i) begin
    if (update_i) begin
      if (victim_way_o) begin
        tag1_q[set_i] <= tag_i;
      end else begin
        tag0_q[set_i] <= tag_i;
      end
    end
  end

  always_ff @(posedge cpu_clock_i) begin
    if (!rst_n_i) begin
      valid0_q <= '0;
      valid1_q <= '0;
      mru_q    <= '0;
    end else begin
      if (update_i) begin
        if (victim_way_o) begin
          valid1_q[set_i] <= 1'b1;
        end else begin
          valid0_q[set_i] <= 1'b1;
        end
      end
      if (mru_touch_i) begin
        mru_q[set_i] <= hit_way_o;
      end
    end
  end

endmodule

/* source/dcache_data_array.sv */
`timescale 1ns/1ps

module dcache_data_array #(
  parameter  int SETS      = 64,
  parameter  int LINE_POW2 = 2,
  localparam int DEPTH     = 2 * SETS * (2 ** LINE_POW2),  // Two ways of SETS lines
  localparam int IDX_W     = $clog2(DEPTH)
) (
  input  logic                              cpu_clock_i,
  input  logic [IDX_W-1:0]                  rd_addr_i,  // {way, set, word}
  output logic [31:0]                       rd_data_o,
  input  logic [IDX_W-1:0]                  wr_addr_i,
  input  logic [31:0]                       wr_data_i,
  input  logic [dcache_pkg::BYTE_LANES-1:0] wr_en_i     // Byte write-enables
);

  logic [31:0] mem_q [DEPTH];

  assign rd_data_o = mem_q[rd_addr_i];  // Asynchronous read

  always_ff @(posedge cpu_clock_i) begin
    for (int b = 0; b < dcache_pkg::BYTE_LANES; b++) begin
      if (wr_en_i[b]) begin
        mem_q[wr_addr_i][b*8 +: 8] <= wr_data_i[b*8 +: 8];
      end
    end
  end

endmodule

/* source/dcache_ctrl.sv */
`timescale 1ns/1ps

module dcache_ctrl #(
  parameter  int SETS      = 64,
  parameter  int LINE_POW2 = 2,
  parameter  int AW        = 12,
  localparam int SET_W     = $clog2(SETS),
  localparam int IDX_W     = $clog2(2 * SETS * (2 ** LINE_POW2)),
  localparam int LANES     = dcache_pkg::BYTE_LANES
) (
  input  logic             cpu_clock_i,
  input  logic             rst_n_i,
  input  logic [AW+1:0]    cpu_addr_i,     // Byte address
  input  logic             cpu_mem_write_i,
  input  logic             cpu_valid_i,
  input  logic [1:0]       hit_i,
  input  logic             victim_way_i,
  input  logic [31:0]      lane_data_i,    // Formatted store data
  input  logic [LANES-1:0] lane_en_i,
  input  logic             stall_i,
  input  logic             ack_i,
  input  logic             err_i,
  output logic             cpu_en_o,       // Low stalls the pipeline
  output logic             fill_o,
  output logic [IDX_W-1:0] fill_addr_o,
  output logic [LANES-1:0] array_wr_en_o,
  output logic             tag_update_o,
  output logic             mru_touch_o,
  output logic             cyc_o,
  output logic             stb_o,
  output logic             we_o,
  output logic [AW-1:0]    adr_o,          // Word address
  output logic [31:0]      dat_o,
  output logic [LANES-1:0] sel_o
);

  localparam int WORDS = 2 ** LINE_POW2;
  localparam int CW    = LINE_POW2 + 1;   // Room to count all WORDS

  dcache_pkg::cache_state_t state_q;

  logic [CW-1:0]    issue_cnt_q;  // Reads accepted by the slave
  logic [CW-1:0]    ack_cnt_q;    // Reads returned
  logic [SET_W-1:0] set;
  logic             any_hit;
  logic             good_ack;
  logic             issue_ok;
  logic             last_issue;
  logic             last_ack;
  logic             store_req;
  logic             miss_load;
  logic             write_done;
  logic             idle;

  assign set        = cpu_addr_i[SET_W+LINE_POW2+1 -: SET_W];
  assign any_hit    = |hit_i;
  assign good_ack   = ack_i & ~err_i;
  assign issue_ok   = stb_o & ~stall_i;
  assign last_issue = issue_cnt_q == CW'(WORDS - 1);
  assign last_ack   = ack_cnt_q == CW'(WORDS - 1);
  assign idle       = state_q == dcache_pkg::CACHE_IDLE;
  assign fill_o     = state_q == dcache_pkg::CACHE_FILL;
  assign store_req  = cpu_valid_i & cpu_mem_write_i;
  assign miss_load  = cpu_valid_i & ~cpu_mem_write_i & ~any_hit;
  assign write_done = (state_q == dcache_pkg::CACHE_WRITE) & ack_i;

  // Stores wait for their ack, loads wait for a hit
  assign cpu_en_o = ~((store_req & ~write_done) | miss_load);

  assign tag_update_o = fill_o & ack_i & last_ack;
  assign mru_touch_o  = idle & cpu_valid_i & ~cpu_mem_write_i & any_hit;

  // Fill words on every clean ack, store bytes only on a hit
  assign array_wr_en_o = fill_o                           ? {LANES{good_ack}} :
                         (write_done & ~err_i & any_hit)  ? lane_en_i : '0;

  if (LINE_POW2 == 0) begin : gen_fill_word
    assign fill_addr_o = {victim_way_i, set};
  end else begin : gen_fill_line
    assign fill_addr_o = {victim_way_i, set, ack_cnt_q[LINE_POW2-1:0]};
  end

  always_ff @(posedge cpu_clock_i) begin
    if (!rst_n_i) begin
      state_q     <= dcache_pkg::CACHE_IDLE;
      cyc_o       <= 1'b0;
      stb_o       <= 1'b0;
      we_o        <= 1'b0;
      issue_cnt_q <= '0;
      ack_cnt_q   <= '0;
    end else begin
      case (state_q)
        dcache_pkg::CACHE_IDLE: begin
          issue_cnt_q <= '0;
          ack_cnt_q   <= '0;
          if (store_req) begin
            state_q <= dcache_pkg::CACHE_WRITE;
            cyc_o   <= 1'b1;
            stb_o   <= 1'b1;
            we_o    <= 1'b1;
          end else if (miss_load) begin
            state_q <= dcache_pkg::CACHE_FILL;
            cyc_o   <= 1'b1;
            stb_o   <= 1'b1;
            we_o    <= 1'b0;
          end
        end
        dcache_pkg::CACHE_WRITE: begin
          if (issue_ok) begin
            stb_o <= 1'b0;
          end
          if (ack_i) begin
            cyc_o   <= 1'b0;
            state_q <= dcache_pkg::CACHE_IDLE;
          end
        end
        dcache_pkg::CACHE_FILL: begin
          if (issue_ok) begin
            issue_cnt_q <= issue_cnt_q + 1'b1;
            if (last_issue) begin
              stb_o <= 1'b0;  // Whole line requested
            end
          end
          if (ack_i) begin
            ack_cnt_q <= ack_cnt_q + 1'b1;
            if (last_ack) begin
              cyc_o   <= 1'b0;
              state_q <= dcache_pkg::CACHE_IDLE;
            end
          end
        end
        default: state_q <= dcache_pkg::CACHE_IDLE;
      endcase
    end
  end

  // Bus payload held while stalled
  always_ff @(posedge cpu_clock_i) begin
    if (idle) begin
      if (store_req) begin
        adr_o <= cpu_addr_i[AW+1:2];
        dat_o <= lane_data_i;
        sel_o <= lane_en_i;
      end else if (miss_load) begin
        adr_o <= cpu_addr_i[AW+1:2] & ~AW'(WORDS - 1);  // Line base
        sel_o <= '1;
      end
    end else if (fill_o && issue_ok && !last_issue) begin
      adr_o <= adr_o + 1'b1;
    end
  end

endmodule

/* source/dcache_top.sv */
`timescale 1ns/1ps

module dcache_top #(
  parameter int SETS      = 64,
  parameter int LINE_POW2 = 2,
  parameter int AW        = 12
) (
  input  logic                              cpu_clock_i,
  input  logic                              rst_n_i,
  input  logic [AW+1:0]                     cpu_addr_i,
  input  logic [31:0]                       cpu_data_i,
  input  logic [2:0]                        cpu_mem_ctrl_i,  // funct3
  input  logic                              cpu_mem_write_i,
  input  logic                              cpu_valid_i,
  output logic [31:0]                       cpu_data_o,
  output logic                              cpu_en_o,
  input  logic                              stall_i,
  input  logic                              ack_i,
  input  logic [31:0]                       dat_i,
  input  logic                              err_i,
  output logic                              cyc_o,
  output logic                              stb_o,
  output logic                              we_o,
  output logic [AW-1:0]                     adr_o,
  output logic [31:0]                       dat_o,
  output logic [dcache_pkg::BYTE_LANES-1:0] sel_o
);

  localparam int SET_W = $clog2(SETS);
  localparam int TAG_W = AW - SET_W - LINE_POW2;
  localparam int IDX_W = $clog2(2 * SETS * (2 ** LINE_POW2));
  localparam int LANES = dcache_pkg::BYTE_LANES;

  logic [TAG_W-1:0] cpu_tag;
  logic [SET_W-1:0] cpu_set;
  logic [1:0]       hit;
  logic             hit_way;
  logic             victim_way;
  logic             fill;
  logic             tag_update;
  logic             mru_touch;
  logic [IDX_W-1:0] fill_addr;
  logic [IDX_W-1:0] rd_addr;
  logic [IDX_W-1:0] wr_addr;
  logic [LANES-1:0] array_wr_en;
  logic [LANES-1:0] lane_en;
  logic [31:0]      lane_data;
  logic [31:0]      ram_data;
  logic [31:0]      wr_data;

  // Byte address is {tag, set, word, byte}
  assign cpu_tag = cpu_addr_i[AW+1 -: TAG_W];
  assign cpu_set = cpu_addr_i[SET_W+LINE_POW2+1 -: SET_W];

  if (LINE_POW2 == 0) begin : gen_rd_word
    assign rd_addr = {hit_way, cpu_set};
  end else begin : gen_rd_line
    assign rd_addr = {hit_way, cpu_set, cpu_addr_i[LINE_POW2+1:2]};
  end

  // Fills take bus data, store hits take the formatted lanes
  assign wr_addr = fill ? fill_addr : rd_addr;
  assign wr_data = fill ? dat_i : lane_data;

  dcache_ctrl #(
    .SETS      (SETS),
    .LINE_POW2 (LINE_POW2),
    .AW        (AW)
  ) u_ctrl (
    .cpu_clock_i     (cpu_clock_i),
    .rst_n_i         (rst_n_i),
    .cpu_addr_i      (cpu_addr_i),
    .cpu_mem_write_i (cpu_mem_write_i),
    .cpu_valid_i     (cpu_valid_i),
    .hit_i           (hit),
    .victim_way_i    (victim_way),
    .lane_data_i     (lane_data),
    .lane_en_i       (lane_en),
    .stall_i         (stall_i),
    .ack_i           (ack_i),
    .err_i           (err_i),
    .cpu_en_o        (cpu_en_o),
    .fill_o          (fill),
    .fill_addr_o     (fill_addr),
    .array_wr_en_o   (array_wr_en),
    .tag_update_o    (tag_update),
    .mru_touch_o     (mru_touch),
    .cyc_o           (cyc_o),
    .stb_o           (stb_o),
    .we_o            (we_o),
    .adr_o           (adr_o),
    .dat_o           (dat_o),
    .sel_o           (sel_o)
  );

  dcache_tag_array #(
    .SETS  (SETS),
    .TAG_W (TAG_W)
  ) u_tag_array (
    .cpu_clock_i  (cpu_clock_i),
    .rst_n_i      (rst_n_i),
    .set_i        (cpu_set),
    .tag_i        (cpu_tag),
    .lookup_i     (cpu_valid_i),
    .hit_o        (hit),
    .hit_way_o    (hit_way),
    .victim_way_o (victim_way),
    .update_i     (tag_update),
    .mru_touch_i  (mru_touch)
  );

  dcache_data_array #(
    .SETS      (SETS),
    .LINE_POW2 (LINE_POW2)
  ) u_data_array (
    .cpu_clock_i (cpu_clock_i),
    .rd_addr_i   (rd_addr),
    .rd_data_o   (ram_data),
    .wr_addr_i   (wr_addr),
    .wr_data_i   (wr_data),
    .wr_en_i     (array_wr_en)
  );

  load_format u_load_format (
    .ram_data_i  (ram_data),
    .byte_off_i  (cpu_addr_i[1:0]),
    .funct3_i    (cpu_mem_ctrl_i),
    .load_data_o (cpu_data_o)
  );

  store_format u_store_format (
    .store_data_i (cpu_data_i),
    .byte_off_i   (cpu_addr_i[1:0]),
    .width_i      (cpu_mem_ctrl_i[1:0]),
    .lane_data_o  (lane_data),
    .lane_en_o    (lane_en)
  );

endmodule

/* tb/wb_mem_model.sv */
`timescale 1ns/1ps

module wb_mem_model #(
  parameter int AW = 12
) (
  input  logic          cpu_clock_i,
  input  logic          rst_n_i,
  input  logic          cyc_i,
  input  logic          stb_i,
  input  logic          we_i,
  input  logic [AW-1:0] adr_i,
  input  logic [31:0]   dat_i,
  input  logic [3:0]    sel_i,
  output logic          stall_o,
  output logic          ack_o,
  output logic [31:0]   dat_o,
  output logic          err_o,
  output logic [31:0]   rd_count_o,     // Accepted reads
  output logic [31:0]   wr_count_o,     // Accepted writes
  output logic [AW-1:0] last_adr_o,
  output logic [31:0]   last_dat_o,
  output logic [3:0]    last_sel_o,
  output logic [31:0]   fault_count_o
);

  localparam logic [31:0] SEED = 32'hae52_1935;

  logic [31:0]    mem [2 ** AW];
  logic [31:0]    resp_q [$];     // Read data waiting for its ack
  logic [31:0]    lfsr;
  logic           hold;           // Request was stalled last cycle
  logic [AW+36:0] hold_payload;
  logic           cyc_seen;
  int             accepted;
  int             acked;

  // Fibonacci LFSR with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic report_fault(input string what);
    fault_count_o = fault_count_o + 1;
    $display("Bus fault at %0t ns: %s", $time, what);
  endtask

  initial begin
    for (int a = 0; a < 2 ** AW; a++) begin
      mem[a] = 32'(a) ^ 32'h5a5a_0000;
    end
    lfsr          = SEED;
    stall_o       = 1'b0;
    ack_o         = 1'b0;
    dat_o         = '0;
    err_o         = 1'b0;  // Never signals an error
    rd_count_o    = '0;
    wr_count_o    = '0;
    last_adr_o    = '0;
    last_dat_o    = '0;
    last_sel_o    = '0;
    fault_count_o = '0;
    hold          = 1'b0;
    cyc_seen      = 1'b0;
    accepted      = 0;
    acked         = 0;
  end

  always @(posedge cpu_clock_i) begin
    if (!rst_n_i) begin
      stall_o <= 1'b0;
      ack_o   <= 1'b0;
      lfsr     = SEED;
      hold     = 1'b0;
      cyc_seen = 1'b0;
      accepted = 0;
      acked    = 0;
      resp_q.delete();
    end else begin
      if (hold && (!stb_i || {we_i, adr_i, dat_i, sel_i} !== hold_payload)) begin
        report_fault("strobe or payload changed while stalled");
      end
      hold         = cyc_i && stb_i && stall_o;
      hold_payload = {we_i, adr_i, dat_i, sel_i};

      if (cyc_seen && !cyc_i && (accepted != acked || resp_q.size() != 0)) begin
        report_fault($sformatf("cycle closed with %0d requests accepted but %0d acked",
                               accepted, acked));
      end
      if (!cyc_i) begin
        accepted = 0;
        acked    = 0;
        resp_q.delete();
      end
      cyc_seen = cyc_i;

      if (cyc_i && stb_i && !stall_o) begin
        accepted++;
        if (we_i) begin
          for (int b = 0; b < 4; b++) begin
            if (sel_i[b]) begin
              mem[adr_i][b*8 +: 8] = dat_i[b*8 +: 8];
            end
          end
          wr_count_o = wr_count_o + 1;
          last_adr_o = adr_i;
          last_dat_o = dat_i;
          last_sel_o = sel_i;
          resp_q.push_back(32'h0);
        end else begin
          rd_count_o = rd_count_o + 1;
          resp_q.push_back(mem[adr_i]);
        end
      end

      lfsr = lfsr_step(lfsr);  // Ack gate
      if (resp_q.size() != 0 && lfsr[0]) begin
        ack_o <= 1'b1;
        dat_o <= resp_q.pop_front();
        acked++;
      end else begin
        ack_o <= 1'b0;
      end
      lfsr = lfsr_step(lfsr);
      stall_o <= lfsr[0];
    end
  end

endmodule

/* tb/tb_dcache.sv */
`timescale 1ns/1ps

module tb_dcache;

  localparam int SETS      = 64;
  localparam int LINE_POW2 = 2;
  localparam int AW        = 12;
  localparam int TIMEOUT   = 200;  // Cycles allowed per request

  logic          cpu_clock;
  logic          rst_n;
  logic [AW+1:0] cpu_addr;
  logic [31:0]   cpu_data;
  logic [2:0]    cpu_mem_ctrl;
  logic          cpu_mem_write;
  logic          cpu_valid;
  logic [31:0]   load_data;
  logic          cpu_en;
  logic          stall;
  logic          ack;
  logic          err;
  logic          cyc;
  logic          stb;
  logic          we;
  logic [AW-1:0] adr;
  logic [31:0]   rd_dat;           // Memory to cache
  logic [31:0]   wr_dat;           // Cache to memory
  logic [3:0]    sel;
  logic [31:0]   rd_count;
  logic [31:0]   wr_count;
  logic [31:0]   fault_count;
  logic [AW-1:0] last_adr;         // Most recent bus write
  logic [31:0]   last_dat;
  logic [3:0]    last_sel;
  int            err_count;
  int            timeouts;

  initial cpu_clock = 1'b0;
  always #4 cpu_clock = ~cpu_clock;  // 8 ns period

  dcache_top #(
    .SETS      (SETS),
    .LINE_POW2 (LINE_POW2),
    .AW        (AW)
  ) u_dcache_top (
    .cpu_clock_i     (cpu_clock),
    .rst_n_i         (rst_n),
    .cpu_addr_i      (cpu_addr),
    .cpu_data_i      (cpu_data),
    .cpu_mem_ctrl_i  (cpu_mem_ctrl),
    .cpu_mem_write_i (cpu_mem_write),
    .cpu_valid_i     (cpu_valid),
    .cpu_data_o      (load_data),
    .cpu_en_o        (cpu_en),
    .stall_i         (stall),
    .ack_i           (ack),
    .dat_i           (rd_dat),
    .err_i           (err),
    .cyc_o           (cyc),
    .stb_o           (stb),
    .we_o            (we),
    .adr_o           (adr),
    .dat_o           (wr_dat),
    .sel_o           (sel)
  );

  wb_mem_model #(
    .AW (AW)
  ) u_mem (
    .cpu_clock_i   (cpu_clock),
    .rst_n_i       (rst_n),
    .cyc_i         (cyc),
    .stb_i         (stb),
    .we_i          (we),
    .adr_i         (adr),
    .dat_i         (wr_dat),
    .sel_i         (sel),
    .stall_o       (stall),
    .ack_o         (ack),
    .dat_o         (rd_dat),
    .err_o         (err),
    .rd_count_o    (rd_count),
    .wr_count_o    (wr_count),
    .last_adr_o    (last_adr),
    .last_dat_o    (last_dat),
    .last_sel_o    (last_sel),
    .fault_count_o (fault_count)
  );

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      err_count++;
      $display("** Error: %s is %h, expected %h at %0t ns", name, got, exp, $time);
    end
  endtask

  // New request goes out just after the rising edge
  task automatic drive_request(input logic is_store, input logic [AW+1:0] addr,
                               input logic [2:0] f3, input logic [31:0] wdata);
    @(posedge cpu_clock);
    #1;
    cpu_addr      = addr;
    cpu_data      = wdata;
    cpu_mem_ctrl  = f3;
    cpu_mem_write = is_store;
    cpu_valid     = 1'b1;
  endtask

  // cpu_en_o is sampled at the falling edge, where it is settled
  task automatic wait_for_enable(output logic done, output logic saw_cyc,
                                 output logic [31:0] data);
    int cycles;
    done    = 1'b0;
    saw_cyc = 1'b0;
    data    = '0;
    cycles  = 0;
    while (!done && cycles < TIMEOUT) begin
      @(negedge cpu_clock);
      if (cyc) begin
        saw_cyc = 1'b1;  // Bus activity during this request
      end
      if (cpu_en) begin
        done = 1'b1;
        data = load_data;
      end
      cycles++;
    end
  endtask

  initial begin
    int          fd;
    int          rc;
    int          fields;
    int          req;
    string       line;
    logic [31:0] op;
    logic [31:0] addr;
    logic [31:0] f3;
    logic [31:0] wdata;
    logic [31:0] exp_val;
    logic [31:0] bus;
    logic [31:0] rd_before;
    logic [31:0] wr_before;
    logic [31:0] data;
    logic        done;
    logic        saw_cyc;

    rst_n         = 1'b0;
    cpu_addr      = '0;
    cpu_data      = '0;
    cpu_mem_ctrl  = '0;
    cpu_mem_write = 1'b0;
    cpu_valid     = 1'b0;
    err_count     = 0;
    timeouts      = 0;
    req           = 0;

    repeat (5) @(posedge cpu_clock);
    #1 rst_n = 1'b1;

    fd = $fopen("tb/dcache_vectors.txt", "r");
    if (fd == 0) begin
      $display("Could not open the vector file tb/dcache_vectors.txt");
      err_count++;
    end else begin
      while (!$feof(fd) && timeouts == 0) begin
        rc = $fgets(line, fd);
        if (rc == 0 || line[0] == "#") begin
          continue;
        end
        fields = $sscanf(line, "%h %h %h %h %h %h", op, addr, f3, wdata, exp_val, bus);
        if (fields != 6) begin
          if (fields > 0) begin
            $display("Malformed vector line: %s", line);
            err_count++;
          end
          continue;
        end
        req++;
        rd_before = rd_count;
        wr_before = wr_count;
        drive_request(op[0], addr[AW+1:0], f3[2:0], wdata);
        wait_for_enable(done, saw_cyc, data);
        if (!done) begin
          $display("Timeout: request %0d at address %h never saw cpu_en_o high in %0d cycles",
                   req, addr, TIMEOUT);
          timeouts++;
        end else if (op[0]) begin
          // Exactly one write-through transfer
          check_value("wr_count delta", wr_count - wr_before, 32'd1);
          check_value("rd_count delta", rd_count - rd_before, 32'd0);
          check_value("adr_o", last_adr, addr >> 2);
          check_value("dat_o", last_dat, exp_val);
          check_value("sel_o", last_sel, bus);
        end else begin
          check_value("cpu_data_o", data, exp_val);
          check_value("rd_count delta", rd_count - rd_before, bus);
          check_value("wr_count delta", wr_count - wr_before, 32'd0);
          check_value("cyc_o seen", saw_cyc, bus != 0);
        end
      end
      $fclose(fd);
    end

    @(posedge cpu_clock);
    #1 cpu_valid = 1'b0;
    repeat (4) @(posedge cpu_clock);  // Let the model see the bus go idle

    if (req == 0) begin
      $display("No requests were read from the vector file");
      err_count++;
    end
    $display("Summary: %0d requests, %0d mismatches, %0d bus faults, %0d timeouts",
             req, err_count, fault_count, timeouts);
    if (err_count == 0 && fault_count == 0 && timeouts == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

/* tb/dcache_vectors.txt */
# op(0 load, 1 store) byte_addr funct3 wdata expect bus, all hex
# Load: expect is cpu_data_o, bus is reads issued. Store: expect is dat_o, bus is sel_o
0 0040 2 00000000 5a5a0010 4
0 0048 2 00000000 5a5a0012 0
0 0044 0 00000000 00000011 0
0 0046 4 00000000 0000005a 0
0 0044 5 00000000 00000011 0
0 0046 1 00000000 00005a5a 0
1 004c 2 80f0c3a5 80f0c3a5 f
0 004c 0 00000000 ffffffa5 0
0 004d 0 00000000 ffffffc3 0
0 004e 0 00000000 fffffff0 0
0 004f 0 00000000 ffffff80 0
0 004d 4 00000000 000000c3 0
0 004f 4 00000000 00000080 0
0 004c 1 00000000 ffffc3a5 0
0 004e 1 00000000 ffff80f0 0
0 004c 5 00000000 0000c3a5 0
0 004e 5 00000000 000080f0 0
0 004c 2 00000000 80f0c3a5 0
1 0041 0 000000e7 e7e7e7e7 2
1 0042 1 1234beef beefbeef c
0 0040 2 00000000 beefe710 0
1 0102 1 cafe9876 98769876 c
0 0100 2 00000000 98760040 4
1 0207 0 0000005c 5c5c5c5c 8
0 0207 4 00000000 0000005c 4
0 0204 2 00000000 5c5a0081 0
0 0480 2 00000000 5a5a0120 4
0 0884 2 00000000 5a5a0221 4
0 0488 2 00000000 5a5a0122 0
0 0c8c 2 00000000 5a5a0323 4
0 048c 2 00000000 5a5a0123 0
0 0880 2 00000000 5a5a0220 4
0 0882 1 00000000 00005a5a 0

/* compile.f */
source/dcache_pkg.sv
source/load_format.sv
source/store_format.sv
source/dcache_tag_array.sv
source/dcache_data_array.sv
source/dcache_ctrl.sv
source/dcache_top.sv
tb/wb_mem_model.sv
tb/tb_dcache.sv

/* Bender.yml */
package:
  name: dcache

sources:
  - source/dcache_pkg.sv
  - source/load_format.sv
  - source/store_format.sv
  - source/dcache_tag_array.sv
  - source/dcache_data_array.sv
  - source/dcache_ctrl.sv
  - source/dcache_top.sv
  - target: test
    files:
      - tb/wb_mem_model.sv
      - tb/tb_dcache.sv
